// ==== source/ecc_cfg_pkg.sv ====
// ECC SRAM configuration constants
// Memory sizes, SECDED parity coverage masks and the register map offsets
`default_nettype none

package ecc_cfg_pkg;

  // Four banks of sixteen words give a 64 word data space
  localparam int NUM_BANKS  = 4;
  localparam int BANK_WORDS = 16;
  localparam int ADDR_W     = 8;
  localparam int OFFS_W     = $clog2(BANK_WORDS);
  localparam int BANK_SEL_W = $clog2(NUM_BANKS);

  // A stored codeword holds seven check bits above the 32 data bits
  localparam int DATA_W = 32;
  localparam int CODE_W = 39;
  localparam int ECC_W  = 7;

  // Rows 0 to 5 are the Hamming checks, each one covering its own check bit 32+j
  // Data bit i sits at the i-th Hamming position that is not a power of two
  // Row 6 covers the whole word and gives the overall parity for double detection
  localparam int PAR_ALL_IDX = 6;
  localparam logic [CODE_W-1:0] PARITY_MASKS [ECC_W] = '{
    39'h01_56AA_AD5B,
    39'h02_9B33_366D,
    39'h04_E3C3_C78E,
    39'h08_03FC_07F0,
    39'h10_03FF_F800,
    39'h20_FC00_0000,
    39'h7F_FFFF_FFFF
  };

  // AXI4-Lite register port
  localparam int         AXIL_ADDR_W     = 8;
  localparam int         AXIL_DATA_W     = 32;
  localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
  localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

  // Per-bank registers follow their base at this byte stride
  localparam int                     REG_STRIDE         = 4;
  localparam logic [AXIL_ADDR_W-1:0] REG_SCRUB_INTERVAL = 8'h00;
  localparam logic [AXIL_ADDR_W-1:0] REG_MISMATCH_BASE  = 8'h10;
  localparam logic [AXIL_ADDR_W-1:0] REG_SCRUB_FIX_BASE = 8'h20;
  localparam logic [AXIL_ADDR_W-1:0] REG_MASK_DATA_BASE = 8'h30;
  localparam logic [AXIL_ADDR_W-1:0] REG_MASK_ECC_BASE  = 8'h40;

endpackage

`default_nettype wire

// ==== source/ecc_types_pkg.sv ====
// ECC SRAM shared types
// Data port, per-bank and AXI4-Lite bundles plus the stored codeword view
`default_nettype none

package ecc_types_pkg;
  import ecc_cfg_pkg::*;

  typedef struct packed {
    logic              valid;
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] rdata;
    logic              corrected;
    logic              uncorrectable;
    logic              dec_err;
  } mem_rsp_t;

  typedef struct packed {
    logic              valid;
    logic              write;
    logic [OFFS_W-1:0] offset;
    logic [DATA_W-1:0] wdata;
  } bank_req_t;

  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] rdata;
    logic              corrected;
    logic              uncorrectable;
  } bank_rsp_t;

  // Signals driven by the AXI4-Lite master
  typedef struct packed {
    logic                   aw_valid;
    logic [AXIL_ADDR_W-1:0] aw_addr;
    logic                   w_valid;
    logic [AXIL_DATA_W-1:0] w_data;
    logic                   b_ready;
    logic                   ar_valid;
    logic [AXIL_ADDR_W-1:0] ar_addr;
    logic                   r_ready;
  } axil_req_t;

  // Signals driven by the AXI4-Lite slave
  typedef struct packed {
    logic                   aw_ready;
    logic                   w_ready;
    logic                   b_valid;
    logic [1:0]             b_resp;
    logic                   ar_ready;
    logic                   r_valid;
    logic [AXIL_DATA_W-1:0] r_data;
    logic [1:0]             r_resp;
  } axil_rsp_t;

  // A cleared wmask_n bit flips that bit of the stored word
  typedef struct packed {
    logic              scrub_trigger;
    logic [CODE_W-1:0] wmask_n;
  } bank_ctrl_t;

  typedef struct packed {
    logic access_fix;
    logic scrub_fix;
  } bank_evt_t;

  typedef struct packed {
    logic [ECC_W-1:0]  ecc;
    logic [DATA_W-1:0] data;
  } codeword_t;

  // The syndrome logic sees the whole word, the datapath sees the fields
  typedef union packed {
    logic [CODE_W-1:0] raw;
    codeword_t         fields;
  } codeword_u;

endpackage

`default_nettype wire

// ==== source/ecc_bank.sv ====
// SECDED protected SRAM bank
// Encodes on write, corrects on read and runs a background scrubber
`default_nettype none

module ecc_bank import ecc_cfg_pkg::*, ecc_types_pkg::*; (
  input  logic       clk_i,
  input  logic       reset_i,
  input  bank_req_t  req_i,
  input  bank_ctrl_t ctrl_i,
  output bank_rsp_t  rsp_o,
  output bank_evt_t  evt_o
);

  // Hamming checks first, then overall parity over data and the six checks
  function automatic codeword_u ecc_encode(logic [DATA_W-1:0] data);
    codeword_u cw;
    cw.fields.data = data;
    cw.fields.ecc  = '0;
    for (int j = 0; j < PAR_ALL_IDX; j++) begin
      cw.fields.ecc[j] = ^(cw.raw & PARITY_MASKS[j]);
    end
    cw.fields.ecc[PAR_ALL_IDX] = ^(cw.raw & PARITY_MASKS[PAR_ALL_IDX]);
    return cw;
  endfunction

  // Syndrome value that a flip of codeword bit b would produce
  function automatic logic [PAR_ALL_IDX-1:0] bit_signature(int b);
    logic [PAR_ALL_IDX-1:0] sig;
    for (int j = 0; j < PAR_ALL_IDX; j++) begin
      sig[j] = PARITY_MASKS[j][b];
    end
    return sig;
  endfunction

  logic [CODE_W-1:0]      mem [BANK_WORDS];
  codeword_u              wr_cw;
  codeword_u              rd_cw;
  codeword_u              fix_cw;
  logic                   rd_valid;
  logic                   rd_write;
  logic                   rd_scrub;
  logic [PAR_ALL_IDX-1:0] syndrome;
  logic                   single_err;
  logic                   double_err;
  logic                   scrub_pend;
  logic                   scrub_go;
  logic                   scrub_wb;
  logic [OFFS_W-1:0]      scrub_ptr;
  logic [OFFS_W-1:0]      scrub_addr;

  assign wr_cw = ecc_encode(req_i.wdata);

  // The scrubber only reads in a cycle that carries no data access
  assign scrub_go = scrub_pend && !req_i.valid;

  // Correction is shared by data reads and scrub reads
  always_comb begin
    for (int j = 0; j < PAR_ALL_IDX; j++) begin
      syndrome[j] = ^(rd_cw.raw & PARITY_MASKS[j]);
    end
    single_err = ^(rd_cw.raw & PARITY_MASKS[PAR_ALL_IDX]);
    double_err = !single_err && (syndrome != '0);
    fix_cw     = rd_cw;
    if (single_err) begin
      // A zero syndrome means only the overall parity bit itself flipped
      if (syndrome == '0) begin
        fix_cw.raw[CODE_W-1] = ~rd_cw.raw[CODE_W-1];
      end
      for (int b = 0; b < CODE_W - 1; b++) begin
        if (syndrome != '0 && bit_signature(b) == syndrome) begin
          fix_cw.raw[b] = ~rd_cw.raw[b];
        end
      end
    end
  end

  // A data write in the write-back cycle wins and the fix is dropped
  assign scrub_wb = rd_valid && rd_scrub && single_err && !(req_i.valid && req_i.write);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_valid   <= 1'b0;
      rd_write   <= 1'b0;
      rd_scrub   <= 1'b0;
      scrub_pend <= 1'b0;
      scrub_ptr  <= '0;
    end else begin
      rd_valid <= req_i.valid || scrub_go;
      rd_write <= req_i.valid && req_i.write;
      rd_scrub <= scrub_go;
      if (ctrl_i.scrub_trigger) begin
        scrub_pend <= 1'b1;
      end else if (scrub_go) begin
        scrub_pend <= 1'b0;
      end
      if (scrub_go) begin
        scrub_ptr <= (scrub_ptr == OFFS_W'(BANK_WORDS - 1)) ? '0 : scrub_ptr + 1'b1;
      end
    end
  end

  // Storage and read register hold payload only
  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      if (req_i.write) begin
        mem[req_i.offset] <= wr_cw.raw ^ ~ctrl_i.wmask_n;
      end else begin
        rd_cw.raw <= mem[req_i.offset];
      end
    end else if (scrub_go) begin
      rd_cw.raw  <= mem[scrub_ptr];
      scrub_addr <= scrub_ptr;
    end
    if (scrub_wb) begin
      mem[scrub_addr] <= fix_cw.raw;
    end
  end

  // Scrub reads stay internal and never show up on the response
  assign rsp_o.valid         = rd_valid && !rd_scrub;
  assign rsp_o.rdata         = rd_write ? '0 : fix_cw.fields.data;
  assign rsp_o.corrected     = !rd_write && single_err;
  assign rsp_o.uncorrectable = !rd_write && double_err;

  assign evt_o.access_fix = rd_valid && !rd_scrub && !rd_write && single_err;
  assign evt_o.scrub_fix  = scrub_wb;

endmodule

`default_nettype wire

// ==== source/bank_decoder.sv ====
// Data port request decoder
// Routes a word request to its bank and flags addresses past the last bank
`default_nettype none

module bank_decoder import ecc_cfg_pkg::*, ecc_types_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  mem_req_t  mem_req_i,
  output bank_req_t bank_req_o [NUM_BANKS],
  output logic      dec_err_o
);

  logic                  out_of_range;
  logic [BANK_SEL_W-1:0] bank_sel;

  // Bits above the bank select must be zero for a mapped word
  assign out_of_range = mem_req_i.addr >= ADDR_W'(NUM_BANKS * BANK_WORDS);
  assign bank_sel     = mem_req_i.addr[OFFS_W +: BANK_SEL_W];

  always_comb begin
    for (int i = 0; i < NUM_BANKS; i++) begin
      bank_req_o[i].valid  = mem_req_i.valid && !out_of_range &&
                             (bank_sel == BANK_SEL_W'(i));
      bank_req_o[i].write  = mem_req_i.write;
      bank_req_o[i].offset = mem_req_i.addr[OFFS_W-1:0];
      bank_req_o[i].wdata  = mem_req_i.wdata;
    end
  end

  // Delayed one cycle so it meets the registered bank responses
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dec_err_o <= 1'b0;
    end else begin
      dec_err_o <= mem_req_i.valid && out_of_range;
    end
  end

endmodule

`default_nettype wire

// ==== source/ecc_manager.sv ====
// ECC manager with an AXI4-Lite register file
// Counts fixes, holds fault injection masks and paces each bank's scrubber
`default_nettype none

module ecc_manager import ecc_cfg_pkg::*, ecc_types_pkg::*; (
  input  logic       clk_i,
  input  logic       reset_i,
  input  axil_req_t  axil_req_i,
  output axil_rsp_t  axil_rsp_o,
  input  bank_evt_t  evt_i [NUM_BANKS],
  output bank_ctrl_t ctrl_o [NUM_BANKS]
);

  logic                   wr_fire;
  logic                   rd_fire;
  logic                   wr_int_hit;
  logic [NUM_BANKS-1:0]   wr_mis_hit;
  logic [NUM_BANKS-1:0]   wr_fix_hit;
  logic [NUM_BANKS-1:0]   wr_mdat_hit;
  logic [NUM_BANKS-1:0]   wr_mecc_hit;
  logic                   wr_mapped;
  logic                   rd_mapped;
  logic [AXIL_DATA_W-1:0] rd_value;
  logic                   b_valid;
  logic [1:0]             b_resp;
  logic                   r_valid;
  logic [AXIL_DATA_W-1:0] r_data;
  logic [1:0]             r_resp;
  logic [AXIL_DATA_W-1:0] scrub_interval;

  logic [NUM_BANKS-1:0][AXIL_DATA_W-1:0] mismatch_cnt;
  logic [NUM_BANKS-1:0][AXIL_DATA_W-1:0] scrub_fix_cnt;
  logic [NUM_BANKS-1:0][AXIL_DATA_W-1:0] scrub_cnt;
  logic [NUM_BANKS-1:0][DATA_W-1:0]      mask_data_n;
  logic [NUM_BANKS-1:0][ECC_W-1:0]       mask_ecc_n;

  // Address and data are taken together while no write response waits
  assign wr_fire = axil_req_i.aw_valid && axil_req_i.w_valid && !b_valid;
  assign rd_fire = axil_req_i.ar_valid && !r_valid;

  assign axil_rsp_o.aw_ready = wr_fire;
  assign axil_rsp_o.w_ready  = wr_fire;
  assign axil_rsp_o.b_valid  = b_valid;
  assign axil_rsp_o.b_resp   = b_resp;
  assign axil_rsp_o.ar_ready = rd_fire;
  assign axil_rsp_o.r_valid  = r_valid;
  assign axil_rsp_o.r_data   = r_data;
  assign axil_rsp_o.r_resp   = r_resp;

  assign wr_int_hit = wr_fire && (axil_req_i.aw_addr == REG_SCRUB_INTERVAL);
  assign wr_mapped  = wr_int_hit || (|wr_mis_hit) || (|wr_fix_hit) ||
                      (|wr_mdat_hit) || (|wr_mecc_hit);

  // Read mux where unmapped offsets return zero data
  always_comb begin
    rd_mapped = 1'b0;
    rd_value  = '0;
    if (axil_req_i.ar_addr == REG_SCRUB_INTERVAL) begin
      rd_mapped = 1'b1;
      rd_value  = scrub_interval;
    end
    for (int i = 0; i < NUM_BANKS; i++) begin
      if (axil_req_i.ar_addr == REG_MISMATCH_BASE + AXIL_ADDR_W'(REG_STRIDE * i)) begin
        rd_mapped = 1'b1;
        rd_value  = mismatch_cnt[i];
      end
      if (axil_req_i.ar_addr == REG_SCRUB_FIX_BASE + AXIL_ADDR_W'(REG_STRIDE * i)) begin
        rd_mapped = 1'b1;
        rd_value  = scrub_fix_cnt[i];
      end
      if (axil_req_i.ar_addr == REG_MASK_DATA_BASE + AXIL_ADDR_W'(REG_STRIDE * i)) begin
        rd_mapped = 1'b1;
        rd_value  = mask_data_n[i];
      end
      if (axil_req_i.ar_addr == REG_MASK_ECC_BASE + AXIL_ADDR_W'(REG_STRIDE * i)) begin
        rd_mapped = 1'b1;
        rd_value  = AXIL_DATA_W'(mask_ecc_n[i]);
      end
    end
  end

  // Responses hold until the master takes them
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      b_valid        <= 1'b0;
      b_resp         <= AXI_RESP_OKAY;
      r_valid        <= 1'b0;
      r_data         <= '0;
      r_resp         <= AXI_RESP_OKAY;
      scrub_interval <= '0;
    end else begin
      if (wr_fire) begin
        b_valid <= 1'b1;
        b_resp  <= wr_mapped ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
      end else if (axil_req_i.b_ready) begin
        b_valid <= 1'b0;
      end
      if (rd_fire) begin
        r_valid <= 1'b1;
        r_data  <= rd_value;
        r_resp  <= rd_mapped ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
      end else if (axil_req_i.r_ready) begin
        r_valid <= 1'b0;
      end
      if (wr_int_hit) begin
        scrub_interval <= axil_req_i.w_data;
      end
    end
  end

  for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_bank_regs
    assign wr_mis_hit[i]  = wr_fire &&
      (axil_req_i.aw_addr == REG_MISMATCH_BASE + AXIL_ADDR_W'(REG_STRIDE * i));
    assign wr_fix_hit[i]  = wr_fire &&
      (axil_req_i.aw_addr == REG_SCRUB_FIX_BASE + AXIL_ADDR_W'(REG_STRIDE * i));
    assign wr_mdat_hit[i] = wr_fire &&
      (axil_req_i.aw_addr == REG_MASK_DATA_BASE + AXIL_ADDR_W'(REG_STRIDE * i));
    assign wr_mecc_hit[i] = wr_fire &&
      (axil_req_i.aw_addr == REG_MASK_ECC_BASE + AXIL_ADDR_W'(REG_STRIDE * i));

    // Any write clears a counter and beats an event in the same cycle
    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        mismatch_cnt[i]  <= '0;
        scrub_fix_cnt[i] <= '0;
        mask_data_n[i]   <= '1;
        mask_ecc_n[i]    <= '1;
        scrub_cnt[i]     <= '0;
      end else begin
        if (wr_mis_hit[i]) begin
          mismatch_cnt[i] <= '0;
        end else if (evt_i[i].access_fix) begin
          mismatch_cnt[i] <= mismatch_cnt[i] + 1'b1;
        end
        if (wr_fix_hit[i]) begin
          scrub_fix_cnt[i] <= '0;
        end else if (evt_i[i].scrub_fix) begin
          scrub_fix_cnt[i] <= scrub_fix_cnt[i] + 1'b1;
        end
        if (wr_mdat_hit[i]) begin
          mask_data_n[i] <= axil_req_i.w_data;
        end
        if (wr_mecc_hit[i]) begin
          mask_ecc_n[i] <= axil_req_i.w_data[ECC_W-1:0];
        end
        // Counts up to the interval and reloads zero, so a trigger every interval+1
        if (scrub_interval == '0 || scrub_cnt[i] >= scrub_interval) begin
          scrub_cnt[i] <= '0;
        end else begin
          scrub_cnt[i] <= scrub_cnt[i] + 1'b1;
        end
      end
    end

    assign ctrl_o[i].scrub_trigger = (scrub_interval != '0) &&
                                     (scrub_cnt[i] >= scrub_interval);
    assign ctrl_o[i].wmask_n       = {mask_ecc_n[i], mask_data_n[i]};
  end

endmodule

`default_nettype wire

// ==== source/rsp_collector.sv ====
// Data port response collector
// Merges the bank responses and decode errors into one registered response
`default_nettype none

module rsp_collector import ecc_cfg_pkg::*, ecc_types_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  bank_rsp_t bank_rsp_i [NUM_BANKS],
  input  logic      dec_err_i,
  output mem_rsp_t  mem_rsp_o
);

  mem_rsp_t sel_rsp;

  // At most one bank answers per cycle, so an OR of the valid ones selects it
  always_comb begin
    sel_rsp = '0;
    for (int i = 0; i < NUM_BANKS; i++) begin
      if (bank_rsp_i[i].valid) begin
        sel_rsp.valid         = 1'b1;
        sel_rsp.rdata         = sel_rsp.rdata | bank_rsp_i[i].rdata;
        sel_rsp.corrected     = sel_rsp.corrected | bank_rsp_i[i].corrected;
        sel_rsp.uncorrectable = sel_rsp.uncorrectable | bank_rsp_i[i].uncorrectable;
      end
    end
    // An out of range request reaches no bank and answers with zero data
    if (dec_err_i) begin
      sel_rsp.valid   = 1'b1;
      sel_rsp.dec_err = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    mem_rsp_o <= sel_rsp;
    if (reset_i) begin
      mem_rsp_o.valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== source/ecc_sram_top.sv ====
// ECC protected SRAM subsystem
// Decoder, banks, response collector and register manager wired together
`default_nettype none

module ecc_sram_top import ecc_cfg_pkg::*, ecc_types_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  mem_req_t  mem_req_i,
  output mem_rsp_t  mem_rsp_o,
  input  axil_req_t axil_req_i,
  output axil_rsp_t axil_rsp_o
);

  bank_req_t  bank_req  [NUM_BANKS];
  bank_rsp_t  bank_rsp  [NUM_BANKS];
  bank_ctrl_t bank_ctrl [NUM_BANKS];
  bank_evt_t  bank_evt  [NUM_BANKS];
  logic       dec_err;

  bank_decoder bank_decoder_i (
    .clk_i      ( clk_i     ),
    .reset_i    ( reset_i   ),
    .mem_req_i  ( mem_req_i ),
    .bank_req_o ( bank_req  ),
    .dec_err_o  ( dec_err   )
  );

  for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_banks
    ecc_bank ecc_bank_i (
      .clk_i   ( clk_i        ),
      .reset_i ( reset_i      ),
      .req_i   ( bank_req[i]  ),
      .ctrl_i  ( bank_ctrl[i] ),
      .rsp_o   ( bank_rsp[i]  ),
      .evt_o   ( bank_evt[i]  )
    );
  end

  rsp_collector rsp_collector_i (
    .clk_i      ( clk_i     ),
    .reset_i    ( reset_i   ),
    .bank_rsp_i ( bank_rsp  ),
    .dec_err_i  ( dec_err   ),
    .mem_rsp_o  ( mem_rsp_o )
  );

  // Register side runs beside the banks and only touches masks and triggers
  ecc_manager ecc_manager_i (
    .clk_i      ( clk_i      ),
    .reset_i    ( reset_i    ),
    .axil_req_i ( axil_req_i ),
    .axil_rsp_o ( axil_rsp_o ),
    .evt_i      ( bank_evt   ),
    .ctrl_o     ( bank_ctrl  )
  );

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
// Testbench clock and reset source
// Free running clock, reset held high for the first rising edges
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Released on a rising edge so it is stable when the stimulus samples it
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== tb/ecc_sram_tb.sv ====
// ECC SRAM subsystem testbench
// Drives the data and register ports and checks against a SECDED reference model
`default_nettype none

module ecc_sram_tb import ecc_cfg_pkg::*, ecc_types_pkg::*; ();

  localparam logic [31:0] SEED        = 32'h1b57_eff6;
  localparam int          MEM_WORDS   = NUM_BANKS * BANK_WORDS;
  // Bank register then collector register, so valid after the second rising edge
  localparam int          RSP_EDGES   = 1;
  localparam int          SCRUB_WORDS = 4;
  localparam int          SCRUB_WAIT  = BANK_WORDS * 4 + 20;
  localparam int          NUM_ACCESS  = 200;
  localparam int          NUM_AXI_OPS = 40;
  localparam int          TIMEOUT     = NUM_ACCESS * 2 + NUM_AXI_OPS * 12 + SCRUB_WAIT + 500;

  typedef struct packed {
    logic [31:0] due;
    mem_rsp_t    rsp;
  } exp_entry_t;

  logic              clk_i;
  logic              reset_i;
  mem_req_t          mem_req;
  mem_rsp_t          mem_rsp;
  axil_req_t         axil_req;
  axil_rsp_t         axil_rsp;
  integer            seed;
  int unsigned       cycle_cnt = 0;
  exp_entry_t        exp_q [$];
  logic [CODE_W-1:0] shadow [MEM_WORDS];
  logic [DATA_W-1:0] mask_data [NUM_BANKS];
  logic [ECC_W-1:0]  mask_ecc [NUM_BANKS];
  int unsigned       fix_reads [NUM_BANKS];

  tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(3)) tb_clock_gen_i (
    .clk_o   ( clk_i   ),
    .reset_o ( reset_i )
  );

  ecc_sram_top ecc_sram_top_i (
    .clk_i      ( clk_i    ),
    .reset_i    ( reset_i  ),
    .mem_req_i  ( mem_req  ),
    .mem_rsp_o  ( mem_rsp  ),
    .axil_req_i ( axil_req ),
    .axil_rsp_o ( axil_rsp )
  );

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
    if (got !== exp) begin
      $display("[ERROR] t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp, got);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // Each check row must see even parity, row 6 being the overall parity
  function automatic logic is_clean(input logic [CODE_W-1:0] cw);
    logic clean;
    clean = 1'b1;
    for (int j = 0; j < ECC_W; j++) begin
      if (^(cw & PARITY_MASKS[j])) begin
        clean = 1'b0;
      end
    end
    return clean;
  endfunction

  function automatic logic [CODE_W-1:0] encode_word(input logic [DATA_W-1:0] data);
    logic [CODE_W-1:0] cw;
    cw = {{ECC_W{1'b0}}, data};
    for (int j = 0; j < ECC_W; j++) begin
      cw[DATA_W+j] = ^(cw & PARITY_MASKS[j]);
    end
    return cw;
  endfunction

  // Searches for the one flipped bit that makes the word a valid codeword
  function automatic logic [CODE_W-1:0] correct_word(input logic [CODE_W-1:0] cw);
    logic [CODE_W-1:0] fixed;
    fixed = cw;
    for (int b = 0; b < CODE_W; b++) begin
      if (is_clean(cw ^ (CODE_W'(1) << b))) begin
        fixed = cw ^ (CODE_W'(1) << b);
      end
    end
    return fixed;
  endfunction

  function automatic mem_rsp_t predict_rsp(input logic [CODE_W-1:0] cw);
    mem_rsp_t          rsp;
    logic [CODE_W-1:0] fixed;
    rsp       = '0;
    rsp.valid = 1'b1;
    rsp.rdata = cw[DATA_W-1:0];
    fixed     = correct_word(cw);
    if (!is_clean(cw) && ^(cw & PARITY_MASKS[ECC_W-1])) begin
      rsp.corrected = 1'b1;
      rsp.rdata     = fixed[DATA_W-1:0];
    end else if (!is_clean(cw)) begin
      rsp.uncorrectable = 1'b1;
    end
    return rsp;
  endfunction

  // Requests are sampled on the rising edge, where the falling-edge drive is stable
  always @(posedge clk_i) begin : track_requests
    exp_entry_t  entry;
    int unsigned bank;
    cycle_cnt = cycle_cnt + 1;
    if (!reset_i && mem_req.valid) begin
      entry           = '0;
      entry.due       = cycle_cnt + RSP_EDGES;
      entry.rsp.valid = 1'b1;
      bank            = mem_req.addr / BANK_WORDS;
      if (mem_req.addr >= MEM_WORDS) begin
        entry.rsp.dec_err = 1'b1;
      end else if (mem_req.write) begin
        shadow[mem_req.addr] = encode_word(mem_req.wdata) ^ ~{mask_ecc[bank], mask_data[bank]};
      end else begin
        entry.rsp = predict_rsp(shadow[mem_req.addr]);
        if (entry.rsp.corrected) begin
          fix_reads[bank]++;
        end
      end
      exp_q.push_back(entry);
    end
  end

  // Responses change on the rising edge and are compared on the falling one
  always @(negedge clk_i) begin : check_responses
    exp_entry_t entry;
    if (!reset_i && mem_rsp.valid) begin
      if (exp_q.size() == 0) begin
        $display("A data port response arrived with no request outstanding at %0t", $time);
        $display("Simulation failed");
        $fatal(1, "unexpected response");
      end else begin
        entry = exp_q.pop_front();
        check_value("mem_rsp_o cycle", entry.due, cycle_cnt);
        check_value("mem_rsp_o", entry.rsp, mem_rsp);
      end
    end else if (!reset_i && exp_q.size() != 0 && exp_q[0].due <= cycle_cnt) begin
      $display("A data port response did not arrive on time at %0t", $time);
      $display("Simulation failed");
      $fatal(1, "missing response");
    end
  end

  initial begin : watchdog
    repeat (TIMEOUT) @(posedge clk_i);
    $display("Timeout: the test did not finish within %0d cycles", TIMEOUT);
    $display("Simulation failed");
    $fatal(1, "timeout");
  end

  task automatic drive_mem(input logic write, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] data);
    @(negedge clk_i);
    mem_req.valid = 1'b1;
    mem_req.write = write;
    mem_req.addr  = addr;
    mem_req.wdata = data;
  endtask

  task automatic drain_mem();
    @(negedge clk_i);
    mem_req = '0;
    do @(posedge clk_i); while (exp_q.size() != 0);
  endtask

  // Holds b ready low for stall cycles and checks that the response stays put
  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                            input int stall, output logic [1:0] resp);
    @(negedge clk_i);
    axil_req.aw_valid = 1'b1;
    axil_req.aw_addr  = addr;
    axil_req.w_valid  = 1'b1;
    axil_req.w_data   = data;
    axil_req.b_ready  = 1'b0;
    do @(posedge clk_i); while (!axil_rsp.aw_ready);
    check_value("w_ready", 1, axil_rsp.w_ready);
    @(negedge clk_i);
    axil_req.aw_valid = 1'b0;
    axil_req.w_valid  = 1'b0;
    check_value("b_valid", 1, axil_rsp.b_valid);
    resp = axil_rsp.b_resp;
    repeat (stall) begin
      @(negedge clk_i);
      check_value("b_valid", 1, axil_rsp.b_valid);
      check_value("b_resp", resp, axil_rsp.b_resp);
    end
    axil_req.b_ready = 1'b1;
    @(negedge clk_i);
    axil_req.b_ready = 1'b0;
    check_value("b_valid", 0, axil_rsp.b_valid);
  endtask

  task automatic axil_read(input logic [7:0] addr, input int stall,
                           output logic [31:0] data, output logic [1:0] resp);
    @(negedge clk_i);
    axil_req.ar_valid = 1'b1;
    axil_req.ar_addr  = addr;
    axil_req.r_ready  = 1'b0;
    do @(posedge clk_i); while (!axil_rsp.ar_ready);
    @(negedge clk_i);
    axil_req.ar_valid = 1'b0;
    check_value("r_valid", 1, axil_rsp.r_valid);
    data = axil_rsp.r_data;
    resp = axil_rsp.r_resp;
    repeat (stall) begin
      @(negedge clk_i);
      check_value("r_valid", 1, axil_rsp.r_valid);
      check_value("r_data", data, axil_rsp.r_data);
      check_value("r_resp", resp, axil_rsp.r_resp);
    end
    axil_req.r_ready = 1'b1;
    @(negedge clk_i);
    axil_req.r_ready = 1'b0;
    check_value("r_valid", 0, axil_rsp.r_valid);
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    logic [1:0] resp;
    axil_write(addr, data, 0, resp);
    check_value("b_resp", AXI_RESP_OKAY, resp);
  endtask

  task automatic read_check(input logic [7:0] addr, input logic [31:0] exp, input string name);
    logic [31:0] data;
    logic [1:0]  resp;
    axil_read(addr, 0, data, resp);
    check_value("r_resp", AXI_RESP_OKAY, resp);
    check_value(name, exp, data);
  endtask

  task automatic set_mask_data(input int bank, input logic [DATA_W-1:0] value);
    write_reg(REG_MASK_DATA_BASE + 8'(REG_STRIDE * bank), value);
    mask_data[bank] = value;
  endtask

  task automatic set_mask_ecc(input int bank, input logic [ECC_W-1:0] value);
    write_reg(REG_MASK_ECC_BASE + 8'(REG_STRIDE * bank), 32'(value));
    mask_ecc[bank] = value;
  endtask

  initial begin : stimulus
    logic [31:0] rdata;
    logic [1:0]  resp;
    int          bit_pos;
    seed     = SEED;
    mem_req  = '0;
    axil_req = '0;
    for (int i = 0; i < NUM_BANKS; i++) begin
      mask_data[i] = '1;
      mask_ecc[i]  = '1;
      fix_reads[i] = 0;
    end
    @(negedge clk_i);
    while (reset_i) @(negedge clk_i);

    // Clean traffic over every word, then a random mix and out of range requests
    for (int i = 0; i < MEM_WORDS; i++) drive_mem(1'b1, ADDR_W'(i), DATA_W'($random(seed)));
    for (int i = 0; i < MEM_WORDS; i++) drive_mem(1'b0, ADDR_W'(i), '0);
    for (int i = 0; i < 32; i++) begin
      drive_mem(1'($random(seed)), ADDR_W'($unsigned($random(seed)) % MEM_WORDS),
                DATA_W'($random(seed)));
    end
    drive_mem(1'b0, 8'd64, '0);
    drive_mem(1'b1, 8'd200, DATA_W'($random(seed)));
    drive_mem(1'b0, 8'hFF, '0);
    drain_mem();

    // Single flips in bank 1 hit a data bit first and then a check bit
    set_mask_data(1, ~(32'd1 << 7));
    drive_mem(1'b1, 8'd21, DATA_W'($random(seed)));
    drain_mem();
    set_mask_data(1, '1);
    repeat (3) drive_mem(1'b0, 8'd21, '0);
    drain_mem();
    set_mask_ecc(1, ~(7'd1 << 2));
    drive_mem(1'b1, 8'd22, DATA_W'($random(seed)));
    drain_mem();
    set_mask_ecc(1, '1);
    repeat (2) drive_mem(1'b0, 8'd22, '0);
    drain_mem();
    read_check(REG_MISMATCH_BASE + 8'd4, fix_reads[1], "mismatch_cnt[1]");
    write_reg(REG_MISMATCH_BASE + 8'd4, 32'hdead_beef);
    fix_reads[1] = 0;
    read_check(REG_MISMATCH_BASE + 8'd4, 0, "mismatch_cnt[1]");

    // A double flip is flagged and leaves the counter alone
    set_mask_data(1, ~((32'd1 << 3) | (32'd1 << 9)));
    drive_mem(1'b1, 8'd23, DATA_W'($random(seed)));
    drain_mem();
    set_mask_data(1, '1);
    drive_mem(1'b0, 8'd23, '0);
    drain_mem();
    read_check(REG_MISMATCH_BASE + 8'd4, fix_reads[1], "mismatch_cnt[1]");

    // Seed single errors in bank 2 and let the scrubber repair them
    for (int i = 0; i < SCRUB_WORDS; i++) begin
      bit_pos = $unsigned($random(seed)) % DATA_W;
      set_mask_data(2, ~(32'd1 << bit_pos));
      drive_mem(1'b1, ADDR_W'(2 * BANK_WORDS + 1 + 4 * i), DATA_W'($random(seed)));
      drain_mem();
    end
    set_mask_data(2, '1);
    write_reg(REG_SCRUB_INTERVAL, 32'd3);
    repeat (SCRUB_WAIT) @(negedge clk_i);
    write_reg(REG_SCRUB_INTERVAL, 32'd0);
    // Every bank is scrubbed, so each single error left in memory is now fixed
    for (int i = 0; i < MEM_WORDS; i++) shadow[i] = correct_word(shadow[i]);
    read_check(REG_SCRUB_FIX_BASE + 8'd8, SCRUB_WORDS, "scrub_fix_cnt[2]");
    for (int i = 0; i < SCRUB_WORDS; i++) drive_mem(1'b0, ADDR_W'(2 * BANK_WORDS + 1 + 4 * i), '0);
    drain_mem();

    // Register read back, unmapped offsets and held responses
    write_reg(REG_SCRUB_INTERVAL, 32'h0000_1234);
    read_check(REG_SCRUB_INTERVAL, 32'h0000_1234, "scrub_interval");
    write_reg(REG_SCRUB_INTERVAL, 32'd0);
    read_check(REG_SCRUB_INTERVAL, 32'd0, "scrub_interval");
    write_reg(REG_MASK_DATA_BASE + 8'd12, 32'h5a5a_c3c3);
    read_check(REG_MASK_DATA_BASE + 8'd12, 32'h5a5a_c3c3, "mask_data[3]");
    write_reg(REG_MASK_ECC_BASE, 32'h0000_0055);
    read_check(REG_MASK_ECC_BASE, 32'h0000_0055, "mask_ecc[0]");
    set_mask_data(3, '1);
    set_mask_ecc(0, '1);
    axil_write(8'h54, 32'h1, 0, resp);
    check_value("b_resp", AXI_RESP_SLVERR, resp);
    axil_read(8'h54, 0, rdata, resp);
    check_value("r_resp", AXI_RESP_SLVERR, resp);
    check_value("r_data", 0, rdata);
    axil_write(REG_SCRUB_INTERVAL, 32'd0, 4, resp);
    check_value("b_resp", AXI_RESP_OKAY, resp);
    axil_read(REG_MASK_DATA_BASE + 8'd12, 4, rdata, resp);
    check_value("r_resp", AXI_RESP_OKAY, resp);
    check_value("r_data", 32'hffff_ffff, rdata);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
source/ecc_cfg_pkg.sv
source/ecc_types_pkg.sv
source/ecc_bank.sv
source/bank_decoder.sv
source/ecc_manager.sv
source/rsp_collector.sv
source/ecc_sram_top.sv
tb/tb_clock_gen.sv
tb/ecc_sram_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the ECC SRAM testbench with Verilator, runs it and judges the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module ecc_sram_tb -f sources.f \
  -o ecc_sram_sim || exit 1
./obj_dir/ecc_sram_sim > sim.log 2>&1
cat sim.log
grep -q "Simulation completed successfully" sim.log && exit 0 || exit 1
